// ==== all.f ====
+incdir+.
reg_bus_pkg.sv
adc_fifo_pkg.sv
host_reg_port.sv
reg_adcfifo.sv
adc_sample_fifo.sv
adc_readout.sv
adc_capture_top.sv
tb_adc_capture.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the ADC capture testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
rm -rf obj_dir "$LOG"
verilator --binary --timing --assert -f all.f --top-module tb_adc_capture -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi
./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if grep -q "Finished with errors" "$LOG"; then
  exit 1
fi
exit 0

// ==== tb_adc_capture.sv ====
`timescale 1ns/1ps
`include "adcfifo_defines.svh"

module tb_adc_capture
  import reg_bus_pkg::*;
  import adc_fifo_pkg::*;
();

  localparam int depth       = 1 << `FIFO_DEPTH_LOG2;
  localparam int cycle_limit = 4000;  // several times the length of all tests

  logic        clk_usb;
  logic        reset;
  adc_sample_t adc_sample;
  logic        adc_valid;
  reg_addr_t   host_addr;
  logic        host_addr_load;
  reg_byte_t   host_wdata;
  logic        host_wr;
  logic        host_rd;
  reg_byte_t   host_rdata;
  logic        segment_ready;

  integer      seed;
  int          errors;
  int          cycles;
  int          pops;         // read strobes the FIFO has seen
  adc_sample_t model_q[$];   // samples the FIFO should hold
  adc_sample_t last_popped;  // data an empty pop repeats

  adc_capture_top UUT (
    .clk_usb        (clk_usb),
    .reset          (reset),
    .adc_sample     (adc_sample),
    .adc_valid      (adc_valid),
    .host_addr      (host_addr),
    .host_addr_load (host_addr_load),
    .host_wdata     (host_wdata),
    .host_wr        (host_wr),
    .host_rd        (host_rd),
    .host_rdata     (host_rdata),
    .segment_ready  (segment_ready)
  );

  initial begin
    clk_usb = 1'b0;
    forever #5 clk_usb = ~clk_usb;  // 100 MHz
  end

  always @(posedge clk_usb) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout: tests still running after %0d clock cycles", cycles);
      $display("Finished with errors");
      $finish;
    end
  end

  task automatic tick(input int n);
    repeat (n) @(posedge clk_usb);
    #1;  // inputs change just after the edge
  endtask

  task automatic check_byte(input reg_byte_t got, input reg_byte_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got 0x%02h expected 0x%02h", $time, what, got, exp);
    end
  endtask

  task automatic check_sample(input adc_sample_t got, input adc_sample_t exp,
                              input string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got 0x%03h expected 0x%03h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic log_bus(input bus_op_t op, input reg_addr_t addr, input reg_byte_t data);
    $display("%0t %s addr %0d data 0x%02h", $time, op.name(), addr, data);
  endtask

  task automatic load_addr(input reg_addr_t addr);
    host_addr      = addr;
    host_addr_load = 1'b1;  // restarts the byte count
    tick(1);
    host_addr_load = 1'b0;
    tick(1);
  endtask

  // bytes go out low byte first
  task automatic bus_write(input reg_addr_t addr, input logic [23:0] bytes, input int count);
    load_addr(addr);
    for (int i = 0; i < count; i++) begin
      host_wdata = bytes[8*i +: 8];
      log_bus(op_write, addr, host_wdata);
      host_wr = 1'b1;  // one cycle pulse per byte
      tick(1);
      host_wr = 1'b0;
      tick(1);
    end
    tick(1);  // clear pulse and register update done
  endtask

  task automatic bus_read(output reg_byte_t data);
    host_rd = 1'b1;
    tick(4);
    data    = host_rdata;  // valid from third cycle of the level
    host_rd = 1'b0;
    tick(1);
  endtask

  task automatic read_reg(input reg_addr_t addr, input int count, output logic [31:0] word);
    reg_byte_t b;
    load_addr(addr);
    word = '0;
    for (int i = 0; i < count; i++) begin
      bus_read(b);
      word[8*i +: 8] = b;
    end
    log_bus(op_read, addr, word[7:0]);
  endtask

  task automatic expect_reg(input reg_addr_t addr, input int count, input logic [31:0] exp,
                            input string what);
    logic [31:0] word;
    read_reg(addr, count, word);
    for (int i = 0; i < count; i++) begin
      check_byte(word[8*i +: 8], exp[8*i +: 8], $sformatf("%s byte %0d", what, i));
    end
  endtask

  task automatic push_samples(input int n);
    for (int i = 0; i < n; i++) begin
      adc_sample = adc_sample_t'($random(seed));
      adc_valid  = 1'b1;
      if (model_q.size() < depth) begin
        model_q.push_back(adc_sample);  // full FIFO drops the rest
      end
      tick(1);
    end
    adc_valid = 1'b0;
  endtask

  function automatic adc_sample_t next_expected();
    adc_sample_t s;
    if (model_q.size() > 0) begin
      s = model_q.pop_front();
    end else begin
      s = last_popped;  // empty pop
    end
    last_popped = s;
    return s;
  endfunction

  task automatic read_samples(input readout_mode_t mode, input int n);
    reg_byte_t   lo;
    reg_byte_t   hi;
    adc_sample_t exp;
    load_addr(`ADCREAD_ADDR);
    for (int i = 0; i < n; i++) begin
      exp  = next_expected();
      pops = pops + 1;
      bus_read(lo);
      case (mode)
        mode_low_res_msb: check_byte(lo, exp[9:2], "low res msb byte");
        mode_low_res_lsb: check_byte(lo, exp[7:0], "low res lsb byte");
        default: begin
          bus_read(hi);  // odd byte does not pop
          check_byte(hi, {6'b0, exp[9:8]}, "full res high byte");
          check_sample({hi[1:0], lo}, exp, "full res sample");
        end
      endcase
    end
  endtask

  task automatic reset_readback();
    expect_reg(`STREAM_SEGMENT_THRESHOLD, 3, 32'h01_0000, "reset threshold");
    expect_reg(`FIFO_NO_UNDERFLOW_ERROR, 1, 32'h1, "reset no underflow error");
    expect_reg(`FIFO_STAT, 2, 32'h0100, "reset fifo status");  // empty set and no errors
    expect_reg(`ADC_LOW_RES, 1, 32'h0, "reset low res");
    bus_write(`STREAM_SEGMENT_THRESHOLD, 24'h01_a5_3c, 3);
    expect_reg(`STREAM_SEGMENT_THRESHOLD, 3, 32'h01_a5_3c, "threshold readback");
  endtask

  task automatic packing_order();
    push_samples(6);
    read_samples(mode_full_res, 2);
    bus_write(`ADC_LOW_RES, 24'h1, 1);  // top bits
    read_samples(mode_low_res_msb, 2);
    bus_write(`ADC_LOW_RES, 24'h3, 1);  // low bits
    read_samples(mode_low_res_lsb, 2);
    expect_reg(`DEBUG_FIFO_READS, 4, pops, "fifo read count");
  endtask

  task automatic fast_read();
    push_samples(3);
    bus_write(`FAST_FIFO_READ_MODE, 24'h1, 1);
    expect_reg(`FAST_FIFO_READ_MODE, 1, 32'h1, "fast mode set");
    read_samples(mode_low_res_lsb, 3);
    bus_write(`ADC_LOW_RES, 24'h0, 1);  // back to full res which ends fast mode
    expect_reg(`FAST_FIFO_READ_MODE, 1, 32'h0, "fast mode after other write");
  endtask

  task automatic overflow_recovery();
    logic [31:0] word;
    logic [31:0] frozen;
    push_samples(depth + 3);
    read_reg(`FIFO_STAT, 2, word);
    check_flag(word[0], 1'b1, "overflow flag after overrun");
    check_flag(word[8], 1'b0, "empty flag with full fifo");
    frozen = pops;  // every earlier pop was error free
    expect_reg(`DEBUG_FIFO_READS_FREEZE, 4, frozen, "freeze count before reads");
    read_samples(mode_full_res, 2);
    expect_reg(`DEBUG_FIFO_READS_FREEZE, 4, frozen, "freeze count during error");
    bus_write(`FIFO_STAT, 24'h0, 1);
    read_reg(`FIFO_STAT, 1, word);
    check_flag(word[0], 1'b0, "overflow flag after clear");
    read_samples(mode_full_res, depth - 2);
    expect_reg(`DEBUG_FIFO_READS_FREEZE, 4, frozen + depth - 2, "freeze count after clear");
    read_reg(`FIFO_STAT, 2, word);
    check_flag(word[8], 1'b1, "empty after draining depth samples");
  endtask

  task automatic underflow_count();
    logic [31:0] word;
    bus_write(`ADC_LOW_RES, 24'h1, 1);  // every read byte pops
    expect_reg(`FIFO_UNDERFLOW_COUNT, 1, 32'h0, "underflow count at start");
    for (int i = 1; i <= 2; i++) begin
      read_samples(mode_low_res_msb, 1);
      expect_reg(`FIFO_UNDERFLOW_COUNT, 1, i, "underflow count");
    end
    read_reg(`FIFO_STAT, 1, word);
    check_flag(word[1], 1'b0, "underflow flag while disabled");
    bus_write(`FIFO_NO_UNDERFLOW_ERROR, 24'h0, 1);
    read_samples(mode_low_res_msb, 1);
    expect_reg(`FIFO_UNDERFLOW_COUNT, 1, 32'h3, "underflow count enabled");
    read_reg(`FIFO_STAT, 1, word);
    check_flag(word[1], 1'b1, "underflow flag once enabled");
    bus_write(`FIFO_STAT, 24'h0, 1);
  endtask

  task automatic segment_threshold();
    bus_write(`STREAM_SEGMENT_THRESHOLD, 24'h00_00_05, 3);
    bus_write(`FIFO_STAT, 24'h0, 1);  // restarts segment count too
    check_flag(segment_ready, 1'b0, "segment ready after restart");
    push_samples(4);
    check_flag(segment_ready, 1'b0, "segment ready after 4 samples");
    push_samples(1);
    check_flag(segment_ready, 1'b1, "segment ready after 5 samples");
  endtask

  initial begin
    seed           = 45;
    errors         = 0;
    pops           = 0;
    last_popped    = '0;
    reset          = 1'b1;
    adc_sample     = '0;
    adc_valid      = 1'b0;
    host_addr      = '0;
    host_addr_load = 1'b0;
    host_wdata     = '0;
    host_wr        = 1'b0;
    host_rd        = 1'b0;
    tick(10);
    reset = 1'b0;
    tick(2);
    reset_readback();
    packing_order();
    fast_read();
    overflow_recovery();
    underflow_count();
    segment_threshold();
    $display("tests done after %0d cycles, %0d errors", cycles, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// ==== adc_capture_top.sv ====
`timescale 1ns/1ps
`include "adcfifo_defines.svh"

module adc_capture_top
  import reg_bus_pkg::*;
  import adc_fifo_pkg::*;
(
  input  logic        clk_usb,
  input  logic        reset,
  input  adc_sample_t adc_sample,
  input  logic        adc_valid,
  input  reg_addr_t   host_addr,
  input  logic        host_addr_load,
  input  reg_byte_t   host_wdata,
  input  logic        host_wr,
  input  logic        host_rd,
  output reg_byte_t   host_rdata,
  output logic        segment_ready
);

  reg_addr_t                reg_address;
  reg_byte_t                reg_datai;
  reg_byte_t                reg_datao;
  logic                     reg_read;
  logic                     reg_write;
  logic [`BYTECNT_SIZE-1:0] reg_bytecnt;
  logic                     fifo_empty;
  fifo_err_t                fifo_error_stat;
  logic [7:0]               underflow_count;
  logic [31:0]              fifo_read_count;
  logic [31:0]              fifo_read_count_error_freeze;
  logic                     fifo_rd_en;
  logic                     clear_fifo_errors;
  logic                     no_underflow_errors;
  seg_thresh_t              stream_segment_threshold;
  readout_mode_t            readout_mode;
  adc_sample_t              fifo_dout;

  host_reg_port u_port (
    .clk_usb        (clk_usb),
    .reset          (reset),
    .host_addr      (host_addr),
    .host_addr_load (host_addr_load),
    .host_wdata     (host_wdata),
    .host_wr        (host_wr),
    .host_rd        (host_rd),
    .reg_address    (reg_address),
    .reg_datai      (reg_datai),
    .reg_read       (reg_read),
    .reg_write      (reg_write),
    .reg_bytecnt    (reg_bytecnt)
  );

  reg_adcfifo u_regs (
    .clk_usb                      (clk_usb),
    .reset                        (reset),
    .reg_address                  (reg_address),
    .reg_bytecnt                  (reg_bytecnt),
    .reg_datai                    (reg_datai),
    .reg_read                     (reg_read),
    .reg_write                    (reg_write),
    .reg_datao                    (reg_datao),
    .fifo_empty                   (fifo_empty),
    .fifo_error_stat              (fifo_error_stat),
    .underflow_count              (underflow_count),
    .fifo_read_count              (fifo_read_count),
    .fifo_read_count_error_freeze (fifo_read_count_error_freeze),
    .fifo_rd_en                   (fifo_rd_en),
    .clear_fifo_errors            (clear_fifo_errors),
    .no_underflow_errors          (no_underflow_errors),
    .stream_segment_threshold     (stream_segment_threshold),
    .readout_mode                 (readout_mode)
  );

  adc_sample_fifo u_fifo (
    .clk_usb                      (clk_usb),
    .reset                        (reset),
    .adc_sample                   (adc_sample),
    .adc_valid                    (adc_valid),
    .fifo_rd_en                   (fifo_rd_en),
    .clear_fifo_errors            (clear_fifo_errors),
    .no_underflow_errors          (no_underflow_errors),
    .stream_segment_threshold     (stream_segment_threshold),
    .fifo_dout                    (fifo_dout),
    .fifo_empty                   (fifo_empty),
    .fifo_error_stat              (fifo_error_stat),
    .underflow_count              (underflow_count),
    .fifo_read_count              (fifo_read_count),
    .fifo_read_count_error_freeze (fifo_read_count_error_freeze),
    .segment_ready                (segment_ready)
  );

  adc_readout u_readout (
    .clk_usb      (clk_usb),
    .reset        (reset),
    .fifo_dout    (fifo_dout),
    .readout_mode (readout_mode),
    .reg_address  (reg_address),
    .reg_bytecnt  (reg_bytecnt),
    .reg_read     (reg_read),
    .reg_datao    (reg_datao),
    .host_rdata   (host_rdata)
  );

endmodule

// ==== adc_readout.sv ====
`timescale 1ns/1ps
`include "adcfifo_defines.svh"

module adc_readout
  import reg_bus_pkg::*;
  import adc_fifo_pkg::*;
(
  input  logic                     clk_usb,
  input  logic                     reset,
  input  adc_sample_t              fifo_dout,
  input  readout_mode_t            readout_mode,
  input  reg_addr_t                reg_address,
  input  logic [`BYTECNT_SIZE-1:0] reg_bytecnt,
  input  logic                     reg_read,
  input  reg_byte_t                reg_datao,
  output reg_byte_t                host_rdata
);

  logic        adc_read;    // read byte in progress at ADCREAD_ADDR
  logic [1:0]  read_age;    // cycles adc_read has been high
  adc_sample_t sample_q;    // held sample
  adc_sample_t sample_cur;
  reg_byte_t   out_byte;

  assign adc_read = reg_read && (reg_address == `ADCREAD_ADDR);

  always_ff @(posedge clk_usb) begin
    if (reset || !adc_read) begin
      read_age <= '0;
    end else if (read_age != 2'd3) begin
      read_age <= read_age + 1'b1;
    end
  end

  // popped word is settled two cycles into the read in either pop mode
  assign sample_cur = (read_age >= 2'd2) ? fifo_dout : sample_q;

  always_ff @(posedge clk_usb) begin
    sample_q <= sample_cur;
  end

  always_comb begin
    case (readout_mode)
      mode_low_res_msb: out_byte = sample_cur[9:2];
      mode_low_res_lsb: out_byte = sample_cur[7:0];
      default: out_byte = reg_bytecnt[0] ? {6'b0, sample_cur[9:8]} : sample_cur[7:0];
    endcase
  end

  assign host_rdata = adc_read ? out_byte : reg_datao;  // other regs pass through

endmodule

// ==== adc_sample_fifo.sv ====
`timescale 1ns/1ps
`include "adcfifo_defines.svh"

module adc_sample_fifo
  import adc_fifo_pkg::*;
(
  input  logic        clk_usb,
  input  logic        reset,
  input  adc_sample_t adc_sample,
  input  logic        adc_valid,
  input  logic        fifo_rd_en,
  input  logic        clear_fifo_errors,
  input  logic        no_underflow_errors,
  input  seg_thresh_t stream_segment_threshold,
  output adc_sample_t fifo_dout,
  output logic        fifo_empty,
  output fifo_err_t   fifo_error_stat,
  output logic [7:0]  underflow_count,
  output logic [31:0] fifo_read_count,
  output logic [31:0] fifo_read_count_error_freeze,
  output logic        segment_ready
);

  localparam int fifo_depth = 1 << `FIFO_DEPTH_LOG2;

  adc_sample_t                 mem [fifo_depth];
  logic [`FIFO_DEPTH_LOG2-1:0] wr_ptr;
  logic [`FIFO_DEPTH_LOG2-1:0] rd_ptr;
  logic [`FIFO_DEPTH_LOG2:0]   fill;           // samples stored
  logic                        fifo_full;
  logic                        push;
  logic                        pop;
  logic                        overflow_evt;   // sample dropped
  logic                        underflow_evt;  // pop on empty
  logic                        overflow_flag;
  logic                        underflow_flag;
  seg_thresh_t                 seg_count;      // samples since last clear

  assign fifo_empty    = (fill == '0);
  assign fifo_full     = fill[`FIFO_DEPTH_LOG2];  // msb set only at depth
  assign push          = adc_valid && !fifo_full;
  assign pop           = fifo_rd_en && !fifo_empty;
  assign overflow_evt  = adc_valid && fifo_full;
  assign underflow_evt = fifo_rd_en && fifo_empty;

  always_ff @(posedge clk_usb) begin
    if (push) begin
      mem[wr_ptr] <= adc_sample;
    end
    if (pop) begin
      fifo_dout <= mem[rd_ptr];  // empty pop keeps last data
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: ;
      endcase
    end
  end

  // sticky flags, clear wins over a new event
  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      overflow_flag  <= 1'b0;
      underflow_flag <= 1'b0;
    end else begin
      if (overflow_evt) overflow_flag <= 1'b1;
      if (underflow_evt && !no_underflow_errors) underflow_flag <= 1'b1;
    end
  end

  assign fifo_error_stat = {6'b0, underflow_flag, overflow_flag};

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      underflow_count              <= '0;
      fifo_read_count              <= '0;
      fifo_read_count_error_freeze <= '0;
    end else begin
      if (underflow_evt && (underflow_count != 8'hff)) begin
        underflow_count <= underflow_count + 1'b1;  // saturates
      end
      if (fifo_rd_en) begin
        fifo_read_count <= fifo_read_count + 1'b1;
      end
      if (fifo_rd_en && (fifo_error_stat == '0)) begin
        fifo_read_count_error_freeze <= fifo_read_count_error_freeze + 1'b1;
      end
    end
  end

  // segment counter restarts with the error clear
  always_ff @(posedge clk_usb) begin
    if (reset || clear_fifo_errors) begin
      seg_count <= '0;
    end else if (adc_valid && (seg_count != '1)) begin
      seg_count <= seg_count + 1'b1;
    end
  end

  assign segment_ready = (seg_count >= stream_segment_threshold);

  assert property (@(posedge clk_usb) disable iff (reset) int'(fill) <= fifo_depth)
    else $error("fifo fill level above depth");

endmodule

// ==== reg_adcfifo.sv ====
`timescale 1ns/1ps
`include "adcfifo_defines.svh"

module reg_adcfifo
  import reg_bus_pkg::*;
  import adc_fifo_pkg::*;
(
  input  logic                     clk_usb,
  input  logic                     reset,
  input  reg_addr_t                reg_address,
  input  logic [`BYTECNT_SIZE-1:0] reg_bytecnt,
  input  reg_byte_t                reg_datai,
  input  logic                     reg_read,
  input  logic                     reg_write,
  output reg_byte_t                reg_datao,
  input  logic                     fifo_empty,
  input  fifo_err_t                fifo_error_stat,
  input  logic [7:0]               underflow_count,
  input  logic [31:0]              fifo_read_count,
  input  logic [31:0]              fifo_read_count_error_freeze,
  output logic                     fifo_rd_en,
  output logic                     clear_fifo_errors,
  output logic                     no_underflow_errors,
  output seg_thresh_t              stream_segment_threshold,
  output readout_mode_t            readout_mode
);

  logic        low_res;              // packed readout enable
  logic        low_res_lsb;          // low bits instead of top bits
  logic        fast_fifo_read_mode;
  logic        reg_read_q;
  logic        read_rise;
  logic        pop_allowed;
  logic        fifo_rd_en_q;         // slow mode pop, one cycle late
  logic [31:0] fifo_stat_word;

  // byte idx of a 32-bit word, zero past the top
  function automatic reg_byte_t pick_byte(input logic [31:0] word,
                                          input logic [`BYTECNT_SIZE-1:0] idx);
    reg_byte_t b;
    if (|idx[`BYTECNT_SIZE-1:2]) begin
      b = '0;
    end else begin
      b = reg_byte_t'(word >> {idx[1:0], 3'b000});
    end
    return b;
  endfunction

  assign fifo_stat_word = {23'b0, fifo_empty, fifo_error_stat};  // empty above error byte

  always_comb begin
    reg_datao = '0;  // idle bus reads zero
    if (reg_read) begin
      case (reg_address)
        `FIFO_STAT:                reg_datao = pick_byte(fifo_stat_word, reg_bytecnt);
        `DEBUG_FIFO_READS:         reg_datao = pick_byte(fifo_read_count, reg_bytecnt);
        `DEBUG_FIFO_READS_FREEZE:
          reg_datao = pick_byte(fifo_read_count_error_freeze, reg_bytecnt);
        `STREAM_SEGMENT_THRESHOLD:
          reg_datao = pick_byte({15'b0, stream_segment_threshold}, reg_bytecnt);
        `ADC_LOW_RES:              reg_datao = {6'b0, low_res_lsb, low_res};
        `FIFO_UNDERFLOW_COUNT:     reg_datao = underflow_count;
        `FIFO_NO_UNDERFLOW_ERROR:  reg_datao = {7'b0, no_underflow_errors};
        `FAST_FIFO_READ_MODE:      reg_datao = {7'b0, fast_fifo_read_mode};
        default:                   reg_datao = '0;
      endcase
    end
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      low_res                  <= 1'b0;
      low_res_lsb              <= 1'b0;
      clear_fifo_errors        <= 1'b0;
      no_underflow_errors      <= 1'b1;  // underflow flag off by default
      stream_segment_threshold <= `SEGMENT_THRESHOLD_RESET;
      fast_fifo_read_mode      <= 1'b0;
    end else begin
      clear_fifo_errors <= reg_write && (reg_address == `FIFO_STAT);  // any write clears
      if (reg_write) begin
        case (reg_address)
          `ADC_LOW_RES: begin
            low_res     <= reg_datai[0];
            low_res_lsb <= reg_datai[1];
          end
          `STREAM_SEGMENT_THRESHOLD: begin
            if (!(|reg_bytecnt[`BYTECNT_SIZE-1:2])) begin
              case (reg_bytecnt[1:0])
                2'd0:    stream_segment_threshold[7:0]  <= reg_datai;
                2'd1:    stream_segment_threshold[15:8] <= reg_datai;
                2'd2:    stream_segment_threshold[16]   <= reg_datai[0];
                default: ;
              endcase
            end
          end
          `FIFO_NO_UNDERFLOW_ERROR: no_underflow_errors <= reg_datai[0];
          default: ;
        endcase
        // fast mode only survives until the next write elsewhere
        fast_fifo_read_mode <= (reg_address == `FAST_FIFO_READ_MODE) ? reg_datai[0] : 1'b0;
      end
    end
  end

  always_comb begin
    if (!low_res) begin
      readout_mode = mode_full_res;
    end else if (low_res_lsb) begin
      readout_mode = mode_low_res_lsb;
    end else begin
      readout_mode = mode_low_res_msb;
    end
  end

  assign read_rise   = reg_read && !reg_read_q;
  // full res pops on the low byte only
  assign pop_allowed = (reg_address == `ADCREAD_ADDR) &&
                       ((readout_mode != mode_full_res) || !reg_bytecnt[0]);

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_read_q   <= 1'b0;
      fifo_rd_en_q <= 1'b0;
    end else begin
      reg_read_q   <= reg_read;
      fifo_rd_en_q <= read_rise && pop_allowed;
    end
  end

  assign fifo_rd_en = fast_fifo_read_mode ? (read_rise && pop_allowed) : fifo_rd_en_q;

  // one clear pulse per FIFO_STAT write, host never writes it back to back
  assert property (@(posedge clk_usb) disable iff (reset)
                   clear_fifo_errors |=> !clear_fifo_errors)
    else $error("clear_fifo_errors held two cycles");

endmodule

// ==== host_reg_port.sv ====
`timescale 1ns/1ps
`include "adcfifo_defines.svh"

module host_reg_port
  import reg_bus_pkg::*;
(
  input  logic                     clk_usb,
  input  logic                     reset,
  input  reg_addr_t                host_addr,
  input  logic                     host_addr_load,
  input  reg_byte_t                host_wdata,
  input  logic                     host_wr,
  input  logic                     host_rd,
  output reg_addr_t                reg_address,
  output reg_byte_t                reg_datai,
  output logic                     reg_read,
  output logic                     reg_write,
  output logic [`BYTECNT_SIZE-1:0] reg_bytecnt
);

  bus_op_t op_q;       // op of this cycle, one behind host pins
  bus_op_t op_prev;    // op of previous cycle
  logic    byte_done;  // end of a byte transfer

  always_ff @(posedge clk_usb) begin
    reg_address <= host_addr;  // address held by host for whole transaction
    reg_datai   <= host_wdata;
  end

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      op_q    <= op_idle;
      op_prev <= op_idle;
    end else begin
      op_prev <= op_q;
      if (host_wr) begin
        op_q <= op_write;  // write wins, both high is a host error
      end else if (host_rd) begin
        op_q <= op_read;
      end else begin
        op_q <= op_idle;
      end
    end
  end

  assign reg_write = (op_q == op_write);
  assign reg_read  = (op_q == op_read);

  // a write byte ends right away, a read byte on the falling edge of reg_read
  assign byte_done = reg_write || ((op_prev == op_read) && (op_q != op_read));

  always_ff @(posedge clk_usb) begin
    if (reset) begin
      reg_bytecnt <= '0;
    end else if (host_addr_load) begin
      reg_bytecnt <= '0;  // new address restarts byte index
    end else if (byte_done) begin
      reg_bytecnt <= reg_bytecnt + 1'b1;
    end
  end

  // host strobes are exclusive
  assert property (@(posedge clk_usb) disable iff (reset) !(host_wr && host_rd))
    else $error("host_wr and host_rd high together");

endmodule

// ==== adc_fifo_pkg.sv ====
package adc_fifo_pkg;

  typedef logic [9:0]  adc_sample_t;  // one ADC conversion
  typedef logic [7:0]  fifo_err_t;    // bit 0 overflow, bit 1 underflow
  typedef logic [16:0] seg_thresh_t;  // samples per stream segment

  // how a sample is packed into read bytes
  typedef enum logic [1:0] {
    mode_full_res    = 2'd0,  // two bytes per sample
    mode_low_res_msb = 2'd1,  // top 8 bits
    mode_low_res_lsb = 2'd2   // bottom 8 bits
  } readout_mode_t;

endpackage

// ==== reg_bus_pkg.sv ====
package reg_bus_pkg;

  // register bus address and data, byte wide
  typedef logic [7:0] reg_addr_t;
  typedef logic [7:0] reg_byte_t;

  // transfer seen on the bus in a cycle
  typedef enum logic [1:0] {
    op_idle  = 2'd0,  // no strobe
    op_read  = 2'd1,  // read level held
    op_write = 2'd2   // write pulse
  } bus_op_t;

endpackage

// ==== adcfifo_defines.svh ====
`ifndef ADCFIFO_DEFINES_SVH
`define ADCFIFO_DEFINES_SVH

// host register map
`define ADCREAD_ADDR             8'd3
`define FIFO_STAT                8'd16
`define DEBUG_FIFO_READS         8'd17
`define DEBUG_FIFO_READS_FREEZE  8'd18
`define STREAM_SEGMENT_THRESHOLD 8'd19
`define ADC_LOW_RES              8'd20
`define FIFO_UNDERFLOW_COUNT     8'd21
`define FIFO_NO_UNDERFLOW_ERROR  8'd22
`define FAST_FIFO_READ_MODE      8'd23

// sample storage
`define FIFO_DEPTH_LOG2          4      // 16 samples

// bus and stream sizing
`define BYTECNT_SIZE             7
`define SEGMENT_THRESHOLD_RESET  17'd65536

`endif
